// File: Makefile
# Verilator build and run for the banked memory testbench

TOP = multi_bank_memory_tb
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -o $(TOP)

# The log is searched for the fail line; a missing pass line also fails
run: build
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "Simulation reported an error"; \
		exit 1; \
	fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "Simulation ended without a result line"; \
		exit 1; \
	fi

lint:
	verilator --lint-only --timing -f files.f --top-module $(TOP)
	verilator --lint-only --timing -f files.f --top-module multi_bank_memory

clean:
	rm -rf obj_dir $(LOG)

// File: files.f
+incdir+hw
hw/bank_mem_pkg.sv
hw/mem_array.sv
hw/bank_group.sv
hw/multi_bank_memory.sv
verif/mem_ref_model.sv
verif/multi_bank_memory_tb.sv

// File: hw/bank_group.sv
`timescale 1ns/10ps
`include "bank_mem_defs.svh"

module bank_group (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 ren,
    input  logic                 wen,
    input  bank_mem_pkg::addr_t  waddr,
    input  bank_mem_pkg::addr_t  raddr,
    input  bank_mem_pkg::data_t  din,
    output bank_mem_pkg::data_t  dout
);

    // Array index fields of both addresses
    bank_mem_pkg::sel_t rsel;
    bank_mem_pkg::sel_t wsel;

    // Row fields of both addresses
    bank_mem_pkg::row_t rrow;
    bank_mem_pkg::row_t wrow;

    // Row that every array of this group sees this cycle
    bank_mem_pkg::row_t row;

    // Per-array strobes
    logic [`BANK_MEM_ARRAYS-1:0] arr_ren;
    logic [`BANK_MEM_ARRAYS-1:0] arr_wen;

    // Per-array read data, zero unless that array was read
    bank_mem_pkg::data_t arr_dout [`BANK_MEM_ARRAYS];

    // ************************************************************
    // Address fields
    // ************************************************************

    assign rsel = raddr[`BANK_MEM_ARR_LSB +: `BANK_MEM_SEL_W];
    assign wsel = waddr[`BANK_MEM_ARR_LSB +: `BANK_MEM_SEL_W];

    assign rrow = raddr[`BANK_MEM_ROW_W-1:0];
    assign wrow = waddr[`BANK_MEM_ROW_W-1:0];

    // ************************************************************
    // Shared row select
    // ************************************************************

    // While the group is read, all four arrays take the read row.
    // A write to a neighbouring array therefore lands at that row too
    always_comb begin
        if (ren) begin
            row = rrow;
        end else begin
            row = wrow;
        end
    end

    // ************************************************************
    // Array strobe decode and storage
    // ************************************************************

    for (genvar a = 0; a < `BANK_MEM_ARRAYS; a++) begin : g_array

        assign arr_ren[a] = ren && (rsel == bank_mem_pkg::sel_t'(a));
        assign arr_wen[a] = wen && (wsel == bank_mem_pkg::sel_t'(a));

        mem_array i_mem_array (
            .clk   (clk),
            .reset (reset),
            .ren   (arr_ren[a]),
            .wen   (arr_wen[a]),
            .addr  (row),
            .din   (din),
            .dout  (arr_dout[a])
        );

    end

    // ************************************************************
    // Output combine
    // ************************************************************

    // At most one array is read at a time, the rest hold zero
    always_comb begin
        dout = '0;
        for (int i = 0; i < `BANK_MEM_ARRAYS; i++) begin
            dout = dout | arr_dout[i];
        end
    end

endmodule

// File: hw/bank_mem_defs.svh
`ifndef BANK_MEM_DEFS_SVH
`define BANK_MEM_DEFS_SVH

// ************************************************************
// Memory geometry
// ************************************************************

// Width of one stored word
`define BANK_MEM_DATA_W 8

// Full word address, 2048 locations
`define BANK_MEM_ADDR_W 11

// Four bank groups, each holding four arrays
`define BANK_MEM_GROUPS 4
`define BANK_MEM_ARRAYS 4

// Rows in one array
`define BANK_MEM_DEPTH 128

// Address field layout: row in 6:0, array in 8:7, group in 10:9
`define BANK_MEM_ROW_W   7
`define BANK_MEM_SEL_W   2
`define BANK_MEM_ARR_LSB 7
`define BANK_MEM_GRP_LSB 9

`endif

// File: hw/bank_mem_pkg.sv
`include "bank_mem_defs.svh"

package bank_mem_pkg;

    // ************************************************************
    // Data and address types
    // ************************************************************

    // Full memory address as seen at the top ports
    typedef logic [`BANK_MEM_ADDR_W-1:0] addr_t;

    // One stored word
    typedef logic [`BANK_MEM_DATA_W-1:0] data_t;

    // Row inside a single array
    typedef logic [`BANK_MEM_ROW_W-1:0] row_t;

    // Group or array index taken from the address
    typedef logic [`BANK_MEM_SEL_W-1:0] sel_t;

    // ************************************************************
    // Per-array access classification
    // ************************************************************

    // What one array does on a clock edge
    //   ACC_IDLE    no strobe, output goes to zero
    //   ACC_READ    read strobe only
    //   ACC_WRITE   write strobe only, din is stored
    //   ACC_BLOCKED both strobes, the read wins and the write is lost
    typedef enum logic [1:0] {
        ACC_IDLE    = 2'd0,
        ACC_READ    = 2'd1,
        ACC_WRITE   = 2'd2,
        ACC_BLOCKED = 2'd3
    } access_e;

endpackage

// File: hw/mem_array.sv
`timescale 1ns/10ps
`include "bank_mem_defs.svh"

module mem_array (
    input  logic                clk,
    input  logic                reset,
    input  logic                ren,
    input  logic                wen,
    input  bank_mem_pkg::row_t  addr,
    input  bank_mem_pkg::data_t din,
    output bank_mem_pkg::data_t dout
);

    bank_mem_pkg::access_e access;

    // Storage, contents survive reset
    bank_mem_pkg::data_t mem [0:`BANK_MEM_DEPTH-1];

    // ************************************************************
    // Access classification
    // ************************************************************

    // A read always has priority over a write to the same array
    always_comb begin
        if (ren && wen) begin
            access = bank_mem_pkg::ACC_BLOCKED;
        end else if (ren) begin
            access = bank_mem_pkg::ACC_READ;
        end else if (wen) begin
            access = bank_mem_pkg::ACC_WRITE;
        end else begin
            access = bank_mem_pkg::ACC_IDLE;
        end
    end

    // ************************************************************
    // Read path
    // ************************************************************

    // An array that is not read drives zero so the levels above can OR
    always_ff @(posedge clk) begin
        if (reset) begin
            dout <= '0;
        end else begin
            case (access)
                bank_mem_pkg::ACC_READ,
                bank_mem_pkg::ACC_BLOCKED: begin
                    dout <= mem[addr];
                end
                default: begin
                    dout <= '0;
                end
            endcase
        end
    end

    // ************************************************************
    // Write path
    // ************************************************************

    always_ff @(posedge clk) begin
        if (access == bank_mem_pkg::ACC_WRITE) begin
            mem[addr] <= din;
        end
    end

endmodule

// File: hw/multi_bank_memory.sv
`timescale 1ns/10ps
`include "bank_mem_defs.svh"

module multi_bank_memory (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 ren,
    input  logic                 wen,
    input  bank_mem_pkg::addr_t  waddr,
    input  bank_mem_pkg::addr_t  raddr,
    input  bank_mem_pkg::data_t  din,
    output bank_mem_pkg::data_t  dout
);

    // Group index fields of both addresses
    bank_mem_pkg::sel_t rgrp;
    bank_mem_pkg::sel_t wgrp;

    // Group-qualified strobes
    logic [`BANK_MEM_GROUPS-1:0] grp_ren;
    logic [`BANK_MEM_GROUPS-1:0] grp_wen;

    // Read data from each bank group
    bank_mem_pkg::data_t grp_dout [`BANK_MEM_GROUPS];

    // ************************************************************
    // Group select
    // ************************************************************

    // Bits 10:9 pick the bank group
    assign rgrp = raddr[`BANK_MEM_GRP_LSB +: `BANK_MEM_SEL_W];
    assign wgrp = waddr[`BANK_MEM_GRP_LSB +: `BANK_MEM_SEL_W];

    // ************************************************************
    // Bank groups
    // ************************************************************

    for (genvar g = 0; g < `BANK_MEM_GROUPS; g++) begin : g_group

        assign grp_ren[g] = ren && (rgrp == bank_mem_pkg::sel_t'(g));
        assign grp_wen[g] = wen && (wgrp == bank_mem_pkg::sel_t'(g));

        // Full addresses go down, each group decodes its own array field
        bank_group i_bank_group (
            .clk   (clk),
            .reset (reset),
            .ren   (grp_ren[g]),
            .wen   (grp_wen[g]),
            .waddr (waddr),
            .raddr (raddr),
            .din   (din),
            .dout  (grp_dout[g])
        );

    end

    // ************************************************************
    // Output combine
    // ************************************************************

    // Groups that were not read return zero, so a plain OR is enough
    always_comb begin
        dout = '0;
        for (int i = 0; i < `BANK_MEM_GROUPS; i++) begin
            dout = dout | grp_dout[i];
        end
    end

endmodule

// File: verif/mem_ref_model.sv
`timescale 1ns/10ps
`include "bank_mem_defs.svh"

module mem_ref_model (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 ren,
    input  logic                 wen,
    input  bank_mem_pkg::addr_t  waddr,
    input  bank_mem_pkg::addr_t  raddr,
    input  bank_mem_pkg::data_t  din,
    output bank_mem_pkg::data_t  exp_dout,
    output logic                 exp_known
);

    localparam int words = `BANK_MEM_GROUPS * `BANK_MEM_ARRAYS * `BANK_MEM_DEPTH;

    bank_mem_pkg::data_t   mem [0:words-1];
    logic                  written [0:words-1];
    bank_mem_pkg::access_e kind;
    bank_mem_pkg::row_t    row;
    bank_mem_pkg::addr_t   target;

    // Kind of access seen by the array that the write aims at
    function automatic bank_mem_pkg::access_e classify(input logic read_hit, input logic write_req);
        if (write_req && read_hit) begin
            return bank_mem_pkg::ACC_BLOCKED;
        end else if (write_req) begin
            return bank_mem_pkg::ACC_WRITE;
        end else if (read_hit) begin
            return bank_mem_pkg::ACC_READ;
        end
        return bank_mem_pkg::ACC_IDLE;
    endfunction

    initial begin
        exp_dout = '0;
        exp_known = 1'b0;
        for (int i = 0; i < words; i++) begin
            written[i] = 1'b0;
        end
    end

    // Read side is evaluated first, so a read in a write cycle sees the old word
    always @(posedge clk) begin
        if (reset || !ren) begin
            exp_dout = '0;
            exp_known = 1'b1;
        end else begin
            exp_dout = mem[raddr];
            exp_known = written[raddr];
        end
        kind = classify(ren && (raddr[`BANK_MEM_ADDR_W-1:`BANK_MEM_ARR_LSB] ==
                                waddr[`BANK_MEM_ADDR_W-1:`BANK_MEM_ARR_LSB]), wen);
        if (kind == bank_mem_pkg::ACC_WRITE) begin
            // A group under read forces the read row onto all its arrays
            if (ren && (raddr[`BANK_MEM_ADDR_W-1:`BANK_MEM_GRP_LSB] ==
                        waddr[`BANK_MEM_ADDR_W-1:`BANK_MEM_GRP_LSB])) begin
                row = raddr[`BANK_MEM_ROW_W-1:0];
            end else begin
                row = waddr[`BANK_MEM_ROW_W-1:0];
            end
            target = {waddr[`BANK_MEM_ADDR_W-1:`BANK_MEM_ARR_LSB], row};
            mem[target] = din;
            written[target] = 1'b1;
        end
    end

endmodule

// File: verif/multi_bank_memory_tb.sv
`timescale 1ns/10ps
`include "bank_mem_defs.svh"

module multi_bank_memory_tb;

    localparam int words = `BANK_MEM_GROUPS * `BANK_MEM_ARRAYS * `BANK_MEM_DEPTH;
    localparam int reset_cycles = 5;
    localparam int idle_cycles = 10;
    localparam int fill_cycles = 2 * words + 2;
    localparam int directed_cycles = 16;
    localparam int random_cycles = 3000;
    localparam int cycle_limit = reset_cycles + idle_cycles + fill_cycles +
                                 directed_cycles + random_cycles + 100;

    logic                clk = 1'b0;
    logic                reset;
    logic                ren;
    logic                wen;
    bank_mem_pkg::addr_t waddr;
    bank_mem_pkg::addr_t raddr;
    bank_mem_pkg::data_t din;
    bank_mem_pkg::data_t dout;
    bank_mem_pkg::data_t exp_dout;
    logic                exp_known;

    logic [31:0] lcg_state = 32'd47707;
    int          cycle_count = 0;
    int          checks_done = 0;

    multi_bank_memory i_multi_bank_memory (
        .clk   (clk),
        .reset (reset),
        .ren   (ren),
        .wen   (wen),
        .waddr (waddr),
        .raddr (raddr),
        .din   (din),
        .dout  (dout)
    );

    mem_ref_model i_mem_ref_model (
        .clk       (clk),
        .reset     (reset),
        .ren       (ren),
        .wen       (wen),
        .waddr     (waddr),
        .raddr     (raddr),
        .din       (din),
        .exp_dout  (exp_dout),
        .exp_known (exp_known)
    );

    always #50 clk = ~clk;

    // ************************************************************
    // Helpers
    // ************************************************************

    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic apply_cycle(input logic r, input logic w, input bank_mem_pkg::addr_t ra,
                               input bank_mem_pkg::addr_t wa, input bank_mem_pkg::data_t d);
        @(posedge clk);
        #1;
        ren = r;
        wen = w;
        raddr = ra;
        waddr = wa;
        din = d;
    endtask

    task automatic check_word(input bank_mem_pkg::data_t expected, input string what);
        assert (dout === expected) else begin
            stop_with_failure($sformatf("Fail at %0d ns: dout = 0x%h, expected 0x%h (%s)",
                                        $time, dout, expected, what));
        end
    endtask

    // ************************************************************
    // Model comparison and timeout
    // ************************************************************

    always @(negedge clk) begin
        if (exp_known) begin
            checks_done++;
            assert (dout === exp_dout) else begin
                stop_with_failure($sformatf("Fail at %0d ns: dout = 0x%h, expected 0x%h",
                                            $time, dout, exp_dout));
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            stop_with_failure($sformatf("Timeout: the test did not end within %0d cycles",
                                        cycle_limit));
        end
    end

    // ************************************************************
    // Stimulus
    // ************************************************************

    initial begin
        logic [15:0] r;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] c;
        reset = 1'b1;
        ren = 1'b0;
        wen = 1'b0;
        waddr = '0;
        raddr = '0;
        din = '0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;
        check_word(8'h00, "after reset");

        // Writes with ren low must leave dout at zero
        for (int i = 0; i < idle_cycles; i++) begin
            r = next_rand();
            a = next_rand();
            b = next_rand();
            apply_cycle(1'b0, r[0], b[`BANK_MEM_ADDR_W-1:0], a[`BANK_MEM_ADDR_W-1:0],
                        r[15:8]);
            check_word(8'h00, "ren low");
        end

        // Fill every address, then read all of them back
        for (int i = 0; i < words; i++) begin
            c = next_rand();
            apply_cycle(1'b0, 1'b1, '0, bank_mem_pkg::addr_t'(i), c[`BANK_MEM_DATA_W-1:0]);
        end
        for (int i = 0; i < words; i++) begin
            apply_cycle(1'b1, 1'b0, bank_mem_pkg::addr_t'(i), '0, '0);
        end
        apply_cycle(1'b0, 1'b0, '0, '0, '0);

        // Read and write of one array in the same cycle drop the write
        apply_cycle(1'b0, 1'b1, '0, 11'h123, 8'h5a);
        apply_cycle(1'b1, 1'b1, 11'h123, 11'h123, 8'ha5);
        apply_cycle(1'b1, 1'b0, 11'h123, '0, '0);
        check_word(8'h5a, "read during blocked write");
        apply_cycle(1'b0, 1'b0, '0, '0, '0);
        check_word(8'h5a, "word after blocked write");

        // Write next to a read in the same group lands on the read row
        apply_cycle(1'b0, 1'b1, '0, {2'd2, 2'd3, 7'd10}, 8'h11);
        apply_cycle(1'b0, 1'b1, '0, {2'd2, 2'd3, 7'd100}, 8'h22);
        apply_cycle(1'b1, 1'b1, {2'd2, 2'd0, 7'd10}, {2'd2, 2'd3, 7'd100}, 8'hc3);
        apply_cycle(1'b1, 1'b0, {2'd2, 2'd3, 7'd10}, '0, '0);
        apply_cycle(1'b1, 1'b0, {2'd2, 2'd3, 7'd100}, '0, '0);
        check_word(8'hc3, "write moved to the read row");
        apply_cycle(1'b0, 1'b0, '0, '0, '0);
        check_word(8'h22, "write row left untouched");

        // A write to another group keeps its own row
        apply_cycle(1'b1, 1'b1, {2'd2, 2'd0, 7'd10}, {2'd1, 2'd3, 7'd100}, 8'h7e);
        apply_cycle(1'b1, 1'b0, {2'd1, 2'd3, 7'd100}, '0, '0);
        apply_cycle(1'b0, 1'b0, '0, '0, '0);
        check_word(8'h7e, "write to another group");

        // Random traffic biased toward shared groups and arrays
        for (int i = 0; i < random_cycles; i++) begin
            r = next_rand();
            a = next_rand();
            b = next_rand();
            c = next_rand();
            if (r[2]) begin
                b[`BANK_MEM_ADDR_W-1:`BANK_MEM_GRP_LSB] = a[`BANK_MEM_ADDR_W-1:`BANK_MEM_GRP_LSB];
            end
            if (r[3] && r[4]) begin
                b[`BANK_MEM_ADDR_W-1:`BANK_MEM_ARR_LSB] = a[`BANK_MEM_ADDR_W-1:`BANK_MEM_ARR_LSB];
            end
            apply_cycle(r[0], r[1], b[`BANK_MEM_ADDR_W-1:0], a[`BANK_MEM_ADDR_W-1:0],
                        c[`BANK_MEM_DATA_W-1:0]);
        end
        apply_cycle(1'b0, 1'b0, '0, '0, '0);
        apply_cycle(1'b0, 1'b0, '0, '0, '0);
        @(posedge clk);

        if (checks_done < words) begin
            stop_with_failure("Too few comparisons against the reference model were made");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule
